// File: Bender.yml
package:
  name: ldpc_encoder

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/ldpc_pkg.sv
      - verilog/ldpc_stage_if.sv
      - verilog/qc_row_product.sv
      - verilog/info_syndrome_stage.sv
      - verilog/parity_stage.sv
      - verilog/ldpc_encoder_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - bench/ldpc_encoder_chk.sv
      - bench/ldpc_encoder_tb.sv

// File: bench/ldpc_encoder_chk.sv
`default_nettype none
`include "ldpc_settings.svh"

// reference model and protocol checks on the encoder ports
module ldpc_encoder_chk
    import ldpc_pkg::*;
(
    input logic                      CLK,
    input logic                      RST,
    input logic                      start,
    input logic [`LDPC_MSG_BITS-1:0] message,
    input logic                      done,
    input logic [`LDPC_CW_BITS-1:0]  codeword
);

    localparam int INFO_KEEP = `LDPC_MSG_BITS - 2 * `LDPC_ZC;  // unpunctured info bits
    localparam int PA_BASE   = INFO_KEEP;
    localparam int PC_BASE   = INFO_KEEP + `LDPC_CORE_ROWS * `LDPC_ZC;

    int   error_count = 0;
    logic seen_start;   // set by the first start after reset

    // cyclic shift of one block, -1 gives the zero block
    function automatic block_t shift_block(block_t b, shift_t s);
        block_t r;
        int     idx;

        r = '0;
        if (s != -1) begin
            for (int m = 0; m < `LDPC_ZC; m++) begin
                idx  = (m + int'(s)) % `LDPC_ZC;
                r[m] = b[idx];
            end
        end
        return r;
    endfunction

    function automatic logic [`LDPC_CW_BITS-1:0] encode_ref(logic [`LDPC_MSG_BITS-1:0] msg);
        block_t                   lam [`LDPC_CORE_ROWS];
        block_t                   pa  [`LDPC_CORE_ROWS];
        block_t                   lam_all;
        block_t                   pc;
        logic [`LDPC_CW_BITS-1:0] cw;

        lam_all = '0;
        for (int r = 0; r < `LDPC_CORE_ROWS; r++) begin
            lam[r] = '0;
            for (int j = 0; j < `LDPC_KB; j++) begin
                lam[r] ^= shift_block(msg[j*`LDPC_ZC +: `LDPC_ZC], A_SHIFTS[r][j]);
            end
            lam_all ^= lam[r];
        end
        pa[0] = (lam_all << 1) | (lam_all >> (`LDPC_ZC - 1));  // rotate left by one
        pa[1] = pa[0] ^ lam[0];
        pa[3] = pa[0] ^ lam[3];
        pa[2] = pa[1] ^ lam[1];

        cw = '0;
        cw[INFO_KEEP-1:0] = msg[`LDPC_MSG_BITS-1:2*`LDPC_ZC];
        for (int k = 0; k < `LDPC_CORE_ROWS; k++) begin
            cw[PA_BASE + k*`LDPC_ZC +: `LDPC_ZC] = pa[k];
        end
        for (int i = 0; i < `LDPC_EXT_ROWS; i++) begin
            pc = '0;
            for (int j = 0; j < `LDPC_KB; j++) begin
                pc ^= shift_block(msg[j*`LDPC_ZC +: `LDPC_ZC], C1_SHIFTS[i][j]);
            end
            for (int k = 0; k < `LDPC_CORE_ROWS; k++) begin
                pc ^= shift_block(pa[k], D_SHIFTS[i][k]);
            end
            cw[PC_BASE + i*`LDPC_ZC +: `LDPC_ZC] = pc;
        end
        return cw;
    endfunction

    always_ff @(posedge CLK or negedge RST) begin
        if (!RST) begin
            seen_start <= 1'b0;
        end else if (start) begin
            seen_start <= 1'b1;
        end
    end

    idle_after_reset: assert property (@(posedge CLK) disable iff (!RST)
        !seen_start |-> (!done && codeword == '0))
        else begin
            error_count++;
            $error("[ERROR] %0t: output active before the first start", $time);
        end

    start_gives_done: assert property (@(posedge CLK) disable iff (!RST)
        start |-> ##2 done)
        else begin
            error_count++;
            $error("[ERROR] %0t: no done two cycles after start", $time);
        end

    done_needs_start: assert property (@(posedge CLK) disable iff (!RST)
        done |-> $past(start, 2))
        else begin
            error_count++;
            $error("[ERROR] %0t: done without a start two cycles earlier", $time);
        end

    codeword_matches: assert property (@(posedge CLK) disable iff (!RST)
        done |-> (codeword == encode_ref($past(message, 2))))
        else begin
            error_count++;
            $error("[ERROR] %0t: codeword %h differs from reference", $time, codeword);
        end

    info_passthrough: assert property (@(posedge CLK) disable iff (!RST)
        done |-> (codeword[INFO_KEEP-1:0] == $past(message[`LDPC_MSG_BITS-1:2*`LDPC_ZC], 2)))
        else begin
            error_count++;
            $error("[ERROR] %0t: systematic bits differ from message", $time);
        end

    zero_in_zero_out: assert property (@(posedge CLK) disable iff (!RST)
        (start && message == '0) |-> ##2 (codeword == '0))
        else begin
            error_count++;
            $error("[ERROR] %0t: zero message gave nonzero codeword", $time);
        end

endmodule

bind ldpc_encoder_top ldpc_encoder_chk u_chk (
    .CLK      (CLK),
    .RST      (RST),
    .start    (start),
    .message  (message),
    .done     (done),
    .codeword (codeword)
);

`default_nettype wire

// File: bench/ldpc_encoder_tb.sv
`default_nettype none
`include "ldpc_settings.svh"

module ldpc_encoder_tb;

    localparam int DONE_TIMEOUT = 20;   // cycles allowed per wait

    logic                      CLK;
    logic                      RST;
    logic                      start;
    logic [`LDPC_MSG_BITS-1:0] message;
    logic                      done;
    logic [`LDPC_CW_BITS-1:0]  codeword;

    logic [31:0] lcg_state;
    int          start_count;
    int          done_count;
    int          timeout_count;
    int          assert_errors;

    ldpc_encoder_top UUT (
        .CLK      (CLK),
        .RST      (RST),
        .start    (start),
        .message  (message),
        .done     (done),
        .codeword (codeword)
    );

    always #10 CLK = ~CLK;

    // done is stable mid-cycle
    always @(negedge CLK) begin
        if (RST && done) begin
            done_count++;
        end
    end

    function automatic logic [31:0] lcg_step(logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic send_message(input logic [`LDPC_MSG_BITS-1:0] m);
        @(posedge CLK);
        #2;
        start   = 1'b1;
        message = m;
        start_count++;
    endtask

    task automatic send_random;
        lcg_state = lcg_step(lcg_state);
        send_message(lcg_state[31:32-`LDPC_MSG_BITS]);   // upper bits, better period
    endtask

    task automatic end_burst;
        @(posedge CLK);
        #2;
        start   = 1'b0;
        message = '0;
    endtask

    // every start should have produced its done strobe
    task automatic wait_results;
        int cycles;

        cycles = 0;
        while (done_count != start_count && cycles < DONE_TIMEOUT) begin
            @(posedge CLK);
            cycles++;
        end
        if (done_count != start_count) begin
            timeout_count++;
            $display("timeout: only %0d of %0d results arrived after %0d cycles",
                     done_count, start_count, cycles);
        end
    endtask

    initial begin
        CLK           = 1'b0;
        RST           = 1'b0;
        start         = 1'b0;
        message       = '0;
        lcg_state     = 32'h8031;
        start_count   = 0;
        done_count    = 0;
        timeout_count = 0;

        repeat (4) @(posedge CLK);
        #2;
        RST = 1'b1;
        repeat (5) @(posedge CLK);  // idle outputs after reset

        // isolated starts
        for (int i = 0; i < 6; i++) begin
            send_random();
            end_burst();
            wait_results();
        end
        send_message('0);
        end_burst();
        wait_results();

        // back to back burst
        for (int i = 0; i < 8; i++) begin
            send_random();
        end
        end_burst();
        wait_results();

        // zero message inside a burst
        send_random();
        send_message('0);
        send_random();
        end_burst();
        wait_results();
        repeat (3) @(posedge CLK);

        assert_errors = UUT.u_chk.error_count;
        $display("summary: %0d starts, %0d results, %0d assertion errors, %0d timeouts",
                 start_count, done_count, assert_errors, timeout_count);
        if (assert_errors == 0 && timeout_count == 0 && done_count == start_count) begin
            $display("*** PASSED ***");
        end else begin
            if (done_count != start_count) begin
                $display("result count does not match the number of starts");
            end
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
+incdir+verilog
verilog/ldpc_pkg.sv
verilog/ldpc_stage_if.sv
verilog/qc_row_product.sv
verilog/info_syndrome_stage.sv
verilog/parity_stage.sv
verilog/ldpc_encoder_top.sv
bench/ldpc_encoder_chk.sv
bench/ldpc_encoder_tb.sv

// File: verilog/info_syndrome_stage.sv
`default_nettype none
`include "ldpc_settings.svh"

// first pipeline stage: message register, lambda and C1 partial products
module info_syndrome_stage
    import ldpc_pkg::*;
(
    input  logic           CLK,
    input  logic           RST,
    input  logic           start,
    input  msg_blocks_t    message,
    ldpc_stage_if.producer stage
);

    core_syn_t   lambda_c;  // A * message
    ext_blocks_t c1_part;   // C1 * message

    // core syndromes, one per core row
    for (genvar r = 0; r < `LDPC_CORE_ROWS; r++) begin : g_a_row
        qc_row_product #(
            .blocks_t   (msg_blocks_t),
            .shifts_t   (msg_shifts_t),
            .N_COLS     (`LDPC_KB),
            .ROW_SHIFTS (A_SHIFTS[r])
        ) u_row (
            .blocks  (message),
            .product (lambda_c[r])
        );
    end

    // info half of every extension row
    for (genvar r = 0; r < `LDPC_EXT_ROWS; r++) begin : g_c1_row
        qc_row_product #(
            .blocks_t   (msg_blocks_t),
            .shifts_t   (msg_shifts_t),
            .N_COLS     (`LDPC_KB),
            .ROW_SHIFTS (C1_SHIFTS[r])
        ) u_row (
            .blocks  (message),
            .product (c1_part[r])
        );
    end

    always_ff @(posedge CLK or negedge RST) begin
        if (!RST) begin
            stage.valid <= 1'b0;
        end else begin
            stage.valid <= start;
        end
    end

    // payload only moves on a start strobe
    always_ff @(posedge CLK) begin
        if (start) begin
            stage.info     <= message;
            stage.lambda   <= lambda_c;
            stage.ext_part <= c1_part;
        end
    end

endmodule

`default_nettype wire

// File: verilog/ldpc_encoder_top.sv
`default_nettype none
`include "ldpc_settings.svh"

// two-stage QC-LDPC encoder, result two cycles after start
module ldpc_encoder_top (
    input  logic                      CLK,
    input  logic                      RST,
    input  logic                      start,
    input  logic [`LDPC_MSG_BITS-1:0] message,
    output logic                      done,
    output logic [`LDPC_CW_BITS-1:0]  codeword
);

    ldpc_stage_if stage_bus ();

    info_syndrome_stage u_info_stage (
        .CLK     (CLK),
        .RST     (RST),
        .start   (start),
        .message (message),
        .stage   (stage_bus.producer)
    );

    parity_stage u_parity_stage (
        .CLK      (CLK),
        .RST      (RST),
        .stage    (stage_bus.consumer),
        .done     (done),
        .codeword (codeword)
    );

endmodule

`default_nettype wire

// File: verilog/ldpc_pkg.sv
`default_nettype none
`include "ldpc_settings.svh"

package ldpc_pkg;

    typedef logic [`LDPC_ZC-1:0] block_t;
    typedef logic signed [3:0]   shift_t;   // -1 marks an all-zero block

    typedef block_t [`LDPC_KB-1:0]        msg_blocks_t;
    typedef block_t [`LDPC_CORE_ROWS-1:0] core_blocks_t;
    typedef block_t [`LDPC_CORE_ROWS-1:0] core_syn_t;
    typedef block_t [`LDPC_EXT_ROWS-1:0]  ext_blocks_t;

    // ascending so the tables read left to right like the base graph
    typedef shift_t [0:`LDPC_KB-1]        msg_shifts_t;
    typedef shift_t [0:`LDPC_CORE_ROWS-1] core_shifts_t;

    localparam shift_t SHIFT_NONE = -1;

    localparam msg_shifts_t A_SHIFTS [`LDPC_CORE_ROWS] = '{
        '{ 1,  1,  0,  0, -1, -1,  1, -1, -1,  1},
        '{ 1, -1, -1,  0,  1,  1,  0,  0,  0,  0},
        '{ 1,  0, -1,  0,  0, -1, -1, -1,  0, -1},
        '{-1,  0,  0, -1,  0,  0,  1,  0,  0,  0}
    };

    localparam msg_shifts_t C1_SHIFTS [`LDPC_EXT_ROWS] = '{
        '{ 1,  0, -1, -1, -1, -1, -1, -1, -1, -1},
        '{ 1,  1, -1, -1, -1,  0, -1,  1, -1, -1},
        '{ 1, -1, -1, -1, -1,  0, -1,  1, -1,  0},
        '{-1,  1, -1, -1, -1,  1, -1,  0, -1, -1},
        '{ 0,  0, -1, -1, -1, -1, -1, -1, -1, -1},
        '{-1,  1, -1, -1, -1, -1, -1, -1,  1, -1},
        '{ 1,  1, -1, -1, -1, -1,  0,  1, -1, -1},
        '{ 1, -1, -1, -1, -1, -1, -1,  0, -1,  0},
        '{-1,  1, -1,  1, -1, -1, -1, -1, -1, -1},
        '{ 1,  0, -1, -1, -1, -1, -1, -1,  0, -1},
        '{-1,  1, -1, -1, -1, -1,  1, -1, -1, -1},
        '{ 1, -1, -1, -1, -1, -1, -1, -1, -1, -1}
    };

    // columns are pa0..pa3
    localparam core_shifts_t D_SHIFTS [`LDPC_EXT_ROWS] = '{
        '{-1,  1, -1, -1},
        '{-1,  1, -1, -1},
        '{-1,  0, -1, -1},
        '{-1,  1, -1,  0},
        '{-1, -1,  0, -1},
        '{ 1,  1, -1, -1},
        '{-1, -1, -1, -1},  // row 6 has no pa term
        '{-1, -1, -1,  0},
        '{-1,  0, -1, -1},
        '{-1, -1, -1,  0},
        '{-1,  1, -1,  0},
        '{ 1,  1, -1, -1}
    };

endpackage

`default_nettype wire

// File: verilog/ldpc_settings.svh
`ifndef LDPC_SETTINGS_SVH
`define LDPC_SETTINGS_SVH

// lifting size, bits per block
`define LDPC_ZC         2

// information columns of the base graph
`define LDPC_KB         10

// double-diagonal core, one parity block per row
`define LDPC_CORE_ROWS  4

// extension rows actually built
`define LDPC_EXT_ROWS   12

`define LDPC_MSG_BITS   (`LDPC_KB * `LDPC_ZC)

// the first two info blocks are punctured from the codeword
`define LDPC_CW_BITS    ((`LDPC_KB - 2 + `LDPC_CORE_ROWS + `LDPC_EXT_ROWS) * `LDPC_ZC)

`endif

// File: verilog/ldpc_stage_if.sv
`default_nettype none

// one encoded item handed from the syndrome stage to the parity stage
interface ldpc_stage_if
    import ldpc_pkg::*;
();

    logic        valid;     // single-cycle strobe
    msg_blocks_t info;      // registered message
    core_syn_t   lambda;    // core syndromes from A
    ext_blocks_t ext_part;  // C1 * message, D term still missing

    modport producer (
        output valid,
        output info,
        output lambda,
        output ext_part
    );

    modport consumer (
        input valid,
        input info,
        input lambda,
        input ext_part
    );

endinterface

`default_nettype wire

// File: verilog/parity_stage.sv
`default_nettype none
`include "ldpc_settings.svh"

// second pipeline stage: core parity solve, extension parity, output register
module parity_stage
    import ldpc_pkg::*;
(
    input  logic                     CLK,
    input  logic                     RST,
    ldpc_stage_if.consumer           stage,
    output logic                     done,
    output logic [`LDPC_CW_BITS-1:0] codeword
);

    block_t       lam_sum;  // xor of all four syndromes
    core_blocks_t pa;       // core parity blocks
    ext_blocks_t  d_part;   // D * pa per extension row
    ext_blocks_t  pc;       // extension parity blocks

    // double-diagonal solve for this graph
    always_comb begin
        lam_sum = stage.lambda[0] ^ stage.lambda[1] ^ stage.lambda[2] ^ stage.lambda[3];

        // rotate left by one
        pa[0] = {lam_sum[`LDPC_ZC-2:0], lam_sum[`LDPC_ZC-1]};
        pa[1] = pa[0] ^ stage.lambda[0];
        pa[3] = pa[0] ^ stage.lambda[3];
        pa[2] = pa[1] ^ stage.lambda[1];
    end

    // parity half of every extension row
    for (genvar r = 0; r < `LDPC_EXT_ROWS; r++) begin : g_d_row
        qc_row_product #(
            .blocks_t   (core_blocks_t),
            .shifts_t   (core_shifts_t),
            .N_COLS     (`LDPC_CORE_ROWS),
            .ROW_SHIFTS (D_SHIFTS[r])
        ) u_row (
            .blocks  (pa),
            .product (d_part[r])
        );
    end

    assign pc = stage.ext_part ^ d_part;

    always_ff @(posedge CLK or negedge RST) begin
        if (!RST) begin
            done     <= 1'b0;
            codeword <= '0;
        end else begin
            done <= stage.valid;
            if (stage.valid) begin
                // info blocks 0 and 1 are punctured
                codeword <= {pc, pa, stage.info[`LDPC_KB-1:2]};
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/qc_row_product.sv
`default_nettype none
`include "ldpc_settings.svh"

// one base-graph row applied to a vector of lifted blocks
module qc_row_product
    import ldpc_pkg::*;
#(
    parameter type     blocks_t   = msg_blocks_t,
    parameter type     shifts_t   = msg_shifts_t,
    parameter int      N_COLS     = `LDPC_KB,
    parameter shifts_t ROW_SHIFTS = '0
) (
    input  blocks_t blocks,
    output block_t  product
);

    always_comb begin
        block_t rot;

        product = '0;
        for (int c = 0; c < N_COLS; c++) begin
            rot = '0;
            if (ROW_SHIFTS[c] != SHIFT_NONE) begin
                // bit m takes source bit (m + s) mod zc
                for (int m = 0; m < `LDPC_ZC; m++) begin
                    rot[m] = blocks[c][(m + ROW_SHIFTS[c]) % `LDPC_ZC];
                end
            end
            product ^= rot;
        end
    end

endmodule

`default_nettype wire
